//--- verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int CSR_NUM_W = 14;
    localparam int DATA_W    = 32;
    localparam int HWI_N     = 8;

    typedef enum logic [2:0] {
        OP_READ  = 3'd0,
        OP_WRITE = 3'd1,
        OP_XCHG  = 3'd2,
        OP_EXCP  = 3'd3,
        OP_ERTN  = 3'd4
    } csr_op_e;

    typedef enum logic [5:0] {
        ECODE_INT = 6'h00,
        ECODE_PIL = 6'h01,
        ECODE_PIS = 6'h02,
        ECODE_PIF = 6'h03,
        ECODE_PME = 6'h04,
        ECODE_PPI = 6'h07,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

    // register numbers of the kept CSRs
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h007;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h00c;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h030;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h031;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h032;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h033;
    localparam logic [CSR_NUM_W-1:0] CSR_TID    = 14'h040;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h044;

endpackage

`default_nettype wire

//--- verilog/csr_issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module csr_issue_ctrl
    import csr_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              req_valid,
    input  wire logic              stall,
    input  wire csr_op_e           req_op,
    input  wire ecode_e            ecode,
    input  wire logic [8:0]        esubcode,
    input  wire logic [DATA_W-1:0] pc,
    input  wire logic              int_pending,
    input  wire logic [DATA_W-1:0] era,
    input  wire logic [DATA_W-1:0] eentry,
    output logic                   do_write,
    output logic                   do_entry,
    output logic                   do_ertn,
    output ecode_e                 entry_ecode,
    output logic      [8:0]        entry_esubcode,
    output logic                   redirect_valid,
    output logic      [DATA_W-1:0] redirect_pc,
    output logic                   excp_flush,
    output logic                   ertn_flush
);

    logic              accept;
    logic              take_int;
    logic              redirect;
    logic [DATA_W-1:0] target_pc;

    assign accept   = req_valid & ~stall;
    // interrupt wins over whatever the pipeline presents
    assign take_int = accept & int_pending;

    always_comb
    begin
        do_write = 1'b0;
        do_entry = 1'b0;
        do_ertn  = 1'b0;
        if (take_int)
        begin
            do_entry = 1'b1;
        end
        else if (accept)
        begin
            case (req_op)
                OP_WRITE, OP_XCHG:
                begin
                    do_write = 1'b1;
                end
                OP_EXCP:
                begin
                    do_entry = 1'b1;
                end
                OP_ERTN:
                begin
                    do_ertn = 1'b1;
                end
                default:
                begin
                    do_write = 1'b0;
                end
            endcase
        end
    end

    // interrupt entry carries code 0, subcode 0
    assign entry_ecode    = int_pending ? ECODE_INT : ecode;
    assign entry_esubcode = int_pending ? 9'd0 : esubcode;

    assign redirect = do_write | do_entry | do_ertn;

    always_comb
    begin
        if (do_entry)
        begin
            target_pc = eentry;
        end
        else if (do_ertn)
        begin
            target_pc = era;
        end
        else
        begin
            // csr write changes state, refetch the next instruction
            target_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            redirect_valid <= 1'b0;
            excp_flush     <= 1'b0;
            ertn_flush     <= 1'b0;
            redirect_pc    <= '0;
        end
        else
        begin
            redirect_valid <= redirect;
            excp_flush     <= do_entry;
            ertn_flush     <= do_ertn;
            if (redirect)
            begin
                redirect_pc <= target_pc;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regfile
    import csr_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic [CSR_NUM_W-1:0] csr_num,
    input  wire logic [DATA_W-1:0]    wdata,
    input  wire logic [DATA_W-1:0]    wmask,
    input  wire logic [DATA_W-1:0]    pc,
    input  wire logic [DATA_W-1:0]    bad_vaddr,
    input  wire logic [HWI_N-1:0]     hwi,
    input  wire logic                 do_write,
    input  wire logic                 do_entry,
    input  wire logic                 do_ertn,
    input  wire ecode_e               entry_ecode,
    input  wire logic [8:0]           entry_esubcode,
    input  wire logic                 timer_flag,
    input  wire logic [DATA_W-1:0]    tcfg,
    input  wire logic [DATA_W-1:0]    tval,
    output logic      [DATA_W-1:0]    rdata,
    output logic      [DATA_W-1:0]    era,
    output logic      [DATA_W-1:0]    eentry,
    output logic                      int_pending,
    output logic      [1:0]           crmd_plv,
    output logic                      crmd_ie,
    output logic                      tcfg_we,
    output logic                      ticlr_we,
    output logic      [DATA_W-1:0]    merged
);

    logic [2:0]        prmd_q;
    logic [12:0]       ecfg_q;
    logic [1:0]        estat_is_q;
    logic [5:0]        estat_ecode_q;
    logic [8:0]        estat_esub_q;
    logic [DATA_W-1:0] badv_q;
    logic [DATA_W-1:6] eentry_q;
    logic [DATA_W-1:0] save_q [4];
    logic [DATA_W-1:0] tid_q;
    logic [11:0]       estat_int;
    logic [DATA_W-1:0] estat_val;
    logic [DATA_W-1:0] old_val;

    // timer at bit 11, bit 10 is not implemented
    assign estat_int   = {timer_flag, 1'b0, hwi, estat_is_q};
    assign estat_val   = {1'b0, estat_esub_q, estat_ecode_q, 4'b0, estat_int};
    assign int_pending = crmd_ie & (|(estat_int & ecfg_q[11:0]));
    assign eentry      = {eentry_q, 6'b0};

    always_comb
    begin
        case (csr_num)
            CSR_CRMD:   old_val = {29'b0, crmd_ie, crmd_plv};
            CSR_PRMD:   old_val = {29'b0, prmd_q};
            CSR_ECFG:   old_val = {19'b0, ecfg_q};
            CSR_ESTAT:  old_val = estat_val;
            CSR_ERA:    old_val = era;
            CSR_BADV:   old_val = badv_q;
            CSR_EENTRY: old_val = eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                old_val = save_q[csr_num[1:0]];
            CSR_TID:    old_val = tid_q;
            CSR_TCFG:   old_val = tcfg;
            CSR_TVAL:   old_val = tval;
            default:    old_val = '0;
        endcase
    end

    assign merged   = (old_val & ~wmask) | (wdata & wmask);
    assign tcfg_we  = do_write && (csr_num == CSR_TCFG);
    assign ticlr_we = do_write && (csr_num == CSR_TICLR);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            rdata         <= '0;
            crmd_plv      <= 2'b0;
            crmd_ie       <= 1'b0;
            prmd_q        <= 3'b0;
            ecfg_q        <= '0;
            estat_is_q    <= 2'b0;
            estat_ecode_q <= 6'b0;
            estat_esub_q  <= 9'b0;
            era           <= '0;
            badv_q        <= '0;
            eentry_q      <= '0;
            tid_q         <= '0;
            for (int i = 0; i < 4; i++)
            begin
                save_q[i] <= '0;
            end
        end
        else
        begin
            rdata <= old_val;
            if (do_write)
            begin
                case (csr_num)
                    CSR_CRMD:
                    begin
                        crmd_plv <= merged[1:0];
                        crmd_ie  <= merged[2];
                    end
                    CSR_PRMD:   prmd_q <= merged[2:0];
                    CSR_ECFG:   ecfg_q <= {merged[12:11], 1'b0, merged[9:0]};
                    CSR_ESTAT:  estat_is_q <= merged[1:0];
                    CSR_ERA:    era <= merged;
                    CSR_BADV:   badv_q <= merged;
                    CSR_EENTRY: eentry_q <= merged[DATA_W-1:6];
                    CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                        save_q[csr_num[1:0]] <= merged;
                    CSR_TID:    tid_q <= merged;
                    default:    tid_q <= tid_q;
                endcase
            end
            else if (do_entry)
            begin
                // save mode, drop to plv0 with interrupts off
                prmd_q        <= {crmd_ie, crmd_plv};
                crmd_plv      <= 2'b0;
                crmd_ie       <= 1'b0;
                era           <= pc;
                estat_ecode_q <= entry_ecode;
                estat_esub_q  <= entry_esubcode;
                if (entry_ecode inside {ECODE_ADE, ECODE_ALE, ECODE_PIL, ECODE_PIS,
                                        ECODE_PIF, ECODE_PME, ECODE_PPI})
                begin
                    badv_q <= bad_vaddr;
                end
            end
            else if (do_ertn)
            begin
                crmd_plv <= prmd_q[1:0];
                crmd_ie  <= prmd_q[2];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/csr_timer.sv
`timescale 1ns/1ps
`default_nettype none

module csr_timer
    import csr_pkg::*;
#(
    parameter int TIMER_W = 32
)
(
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              tcfg_we,
    input  wire logic              ticlr_we,
    input  wire logic [DATA_W-1:0] merged,
    output logic      [DATA_W-1:0] tcfg,
    output logic      [DATA_W-1:0] tval,
    output logic                   timer_flag
);

    logic [TIMER_W-1:0] tcfg_q;
    logic [TIMER_W-1:0] tval_q;
    logic               load_pend;
    logic [TIMER_W-1:0] init_val;
    logic               hit_zero;

    assign init_val = {tcfg_q[TIMER_W-1:2], 2'b00};
    assign tcfg     = DATA_W'(tcfg_q);
    assign tval     = DATA_W'(tval_q);
    // counter steps from 1 to 0 this cycle
    assign hit_zero = tcfg_q[0] && !load_pend && (tval_q == TIMER_W'(1));

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg_q     <= '0;
            tval_q     <= '0;
            load_pend  <= 1'b0;
            timer_flag <= 1'b0;
        end
        else
        begin
            load_pend <= tcfg_we & merged[0];
            if (tcfg_we)
            begin
                tcfg_q <= merged[TIMER_W-1:0];
            end
            if (load_pend)
            begin
                tval_q <= init_val;
            end
            else if (hit_zero)
            begin
                // periodic mode reloads, one-shot stays at 0
                tval_q <= tcfg_q[1] ? init_val : '0;
            end
            else if (tcfg_q[0] && (tval_q != '0))
            begin
                tval_q <= tval_q - 1'b1;
            end
            if (hit_zero)
            begin
                timer_flag <= 1'b1;
            end
            else if (ticlr_we && merged[0])
            begin
                timer_flag <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import csr_pkg::*;
#(
    parameter int TIMER_W = 32
)
(
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 req_valid,
    input  wire logic                 stall,
    input  wire csr_op_e              req_op,
    input  wire logic [CSR_NUM_W-1:0] csr_num,
    input  wire logic [DATA_W-1:0]    wdata,
    input  wire logic [DATA_W-1:0]    wmask,
    input  wire logic [DATA_W-1:0]    pc,
    input  wire ecode_e               ecode,
    input  wire logic [8:0]           esubcode,
    input  wire logic [DATA_W-1:0]    bad_vaddr,
    input  wire logic [HWI_N-1:0]     hwi,
    output logic      [DATA_W-1:0]    rdata,
    output logic                      redirect_valid,
    output logic      [DATA_W-1:0]    redirect_pc,
    output logic                      excp_flush,
    output logic                      ertn_flush,
    output logic      [1:0]           crmd_plv,
    output logic                      crmd_ie
);

    logic              do_write;
    logic              do_entry;
    logic              do_ertn;
    ecode_e            entry_ecode;
    logic [8:0]        entry_esubcode;
    logic              int_pending;
    logic [DATA_W-1:0] era;
    logic [DATA_W-1:0] eentry;
    logic              timer_flag;
    logic [DATA_W-1:0] tcfg;
    logic [DATA_W-1:0] tval;
    logic              tcfg_we;
    logic              ticlr_we;
    logic [DATA_W-1:0] merged;

    csr_issue_ctrl u_issue_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .req_valid      (req_valid),
        .stall          (stall),
        .req_op         (req_op),
        .ecode          (ecode),
        .esubcode       (esubcode),
        .pc             (pc),
        .int_pending    (int_pending),
        .era            (era),
        .eentry         (eentry),
        .do_write       (do_write),
        .do_entry       (do_entry),
        .do_ertn        (do_ertn),
        .entry_ecode    (entry_ecode),
        .entry_esubcode (entry_esubcode),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .excp_flush     (excp_flush),
        .ertn_flush     (ertn_flush)
    );

    // plain write takes the whole register
    csr_regfile u_regfile (
        .clk            (clk),
        .rstn           (rstn),
        .csr_num        (csr_num),
        .wdata          (wdata),
        .wmask          ((req_op == OP_WRITE) ? {DATA_W{1'b1}} : wmask),
        .pc             (pc),
        .bad_vaddr      (bad_vaddr),
        .hwi            (hwi),
        .do_write       (do_write),
        .do_entry       (do_entry),
        .do_ertn        (do_ertn),
        .entry_ecode    (entry_ecode),
        .entry_esubcode (entry_esubcode),
        .timer_flag     (timer_flag),
        .tcfg           (tcfg),
        .tval           (tval),
        .rdata          (rdata),
        .era            (era),
        .eentry         (eentry),
        .int_pending    (int_pending),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .tcfg_we        (tcfg_we),
        .ticlr_we       (ticlr_we),
        .merged         (merged)
    );

    csr_timer #(
        .TIMER_W (TIMER_W)
    ) u_timer (
        .clk        (clk),
        .rstn       (rstn),
        .tcfg_we    (tcfg_we),
        .ticlr_we   (ticlr_we),
        .merged     (merged),
        .tcfg       (tcfg),
        .tval       (tval),
        .timer_flag (timer_flag)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
)
(
    output logic clk,
    output logic rstn
);

    initial
    begin
        clk  = 1'b0;
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rstn = 1'b1;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- bench/csr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module csr_checker (
    input  wire logic        clk,
    input  wire logic        check_en,
    input  var  int          test_id,
    input  wire logic [31:0] exp_rdata,
    input  wire logic        exp_redir,
    input  wire logic [31:0] exp_target,
    input  wire logic        exp_excp,
    input  wire logic        exp_ertn,
    input  wire logic [1:0]  exp_plv,
    input  wire logic        exp_ie,
    input  wire logic [31:0] rdata,
    input  wire logic        redirect_valid,
    input  wire logic [31:0] redirect_pc,
    input  wire logic        excp_flush,
    input  wire logic        ertn_flush,
    input  wire logic [1:0]  crmd_plv,
    input  wire logic        crmd_ie,
    output int               errors
);

    int tests;
    int bad;

    initial
    begin
        tests  = 0;
        errors = 0;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            bad++;
        end
    endtask

    // outputs are stable mid-cycle after the accepting edge
    always @(negedge clk)
    begin
        if (check_en)
        begin
            bad = 0;
            compare("rdata", rdata, exp_rdata);
            compare("redirect_valid", 32'(redirect_valid), 32'(exp_redir));
            if (exp_redir)
            begin
                compare("redirect_pc", redirect_pc, exp_target);
            end
            compare("excp_flush", 32'(excp_flush), 32'(exp_excp));
            compare("ertn_flush", 32'(ertn_flush), 32'(exp_ertn));
            compare("crmd_plv", 32'(crmd_plv), 32'(exp_plv));
            compare("crmd_ie", 32'(crmd_ie), 32'(exp_ie));
            tests++;
            if (bad != 0)
            begin
                errors++;
                $display("test %0d failed", test_id);
            end
            else
            begin
                $display("test %0d passed", test_id);
            end
        end
    end

    task automatic print_counts();
        $display("tests run %0d, passed %0d, failed %0d", tests, tests - errors, errors);
    endtask

endmodule

`default_nettype wire

//--- bench/csr_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_assertions
    import csr_pkg::*;
(
    input wire logic              clk,
    input wire logic              rstn,
    input wire logic              req_valid,
    input wire logic              stall,
    input wire logic              redirect_valid,
    input wire logic [DATA_W-1:0] redirect_pc,
    input wire logic              excp_flush,
    input wire logic              ertn_flush,
    input wire logic [DATA_W-1:0] rdata,
    input wire logic [1:0]        crmd_plv,
    input wire logic              crmd_ie
);

    a_redirect_cause: assert property (@(posedge clk) disable iff (!rstn)
        $rose(redirect_valid) |-> $past(req_valid && !stall))
        else $error("redirect without an accepted request");

    a_flush_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush))
        else $error("both flushes high");

    a_flush_redirect: assert property (@(posedge clk) disable iff (!rstn)
        (excp_flush || ertn_flush) |-> redirect_valid)
        else $error("flush without redirect");

    a_reset_out: assert property (@(posedge clk)
        $past(!rstn) |-> (!redirect_valid && !excp_flush && !ertn_flush && rdata == '0
                          && redirect_pc == '0 && crmd_plv == 2'b0 && !crmd_ie))
        else $error("outputs not cleared by reset");

endmodule

bind csr_unit csr_unit_assertions u_assertions (
    .clk            (clk),
    .rstn           (rstn),
    .req_valid      (req_valid),
    .stall          (stall),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .excp_flush     (excp_flush),
    .ertn_flush     (ertn_flush),
    .rdata          (rdata),
    .crmd_plv       (crmd_plv),
    .crmd_ie        (crmd_ie)
);

`default_nettype wire

//--- bench/tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit
    import csr_pkg::*;
;

    localparam logic [31:0] EENTRY_VAL = 32'h1c008000;
    localparam int          INIT_VAL   = 2;
    localparam int          POLL_BOUND = (INIT_VAL << 2) + 4;
    localparam int          ROW_COUNT  = 30;
    localparam int          LIMIT      = ROW_COUNT * 2 + POLL_BOUND + 20;

    typedef struct {
        csr_op_e     op;
        logic [13:0] num;
        logic [31:0] wdata;
        logic [31:0] wmask;
        logic [31:0] pc;
        ecode_e      ecode;
        logic [31:0] badv;
        logic        stall_col;
        logic [31:0] exp_rdata;
        logic [31:0] exp_alt;
        logic        exp_redir;
        logic [31:0] exp_target;
        logic        exp_excp;
        logic        exp_ertn;
        logic [1:0]  exp_plv;
        logic        exp_ie;
    } row_t;

    logic clk;
    logic rstn;
    logic req_valid;
    logic stall;
    csr_op_e req_op;
    logic [CSR_NUM_W-1:0] csr_num;
    logic [31:0] wdata;
    logic [31:0] wmask;
    logic [31:0] pc;
    ecode_e ecode;
    logic [8:0] esubcode;
    logic [31:0] bad_vaddr;
    logic [HWI_N-1:0] hwi;
    logic [31:0] rdata;
    logic redirect_valid;
    logic [31:0] redirect_pc;
    logic excp_flush;
    logic ertn_flush;
    logic [1:0] crmd_plv;
    logic crmd_ie;

    logic check_en;
    int test_id;
    logic [31:0] exp_rdata;
    logic exp_redir;
    logic [31:0] exp_target;
    logic exp_excp;
    logic exp_ertn;
    logic [1:0] exp_plv;
    logic exp_ie;
    int errors;

    row_t rows[$];
    integer seed;
    logic prev_stalled;
    logic poll_failed;
    int cycles;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(3)) u_clock_gen (.clk(clk), .rstn(rstn));

    csr_unit #(.TIMER_W(32)) u_dut (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .stall(stall), .req_op(req_op),
        .csr_num(csr_num), .wdata(wdata), .wmask(wmask), .pc(pc), .ecode(ecode),
        .esubcode(esubcode), .bad_vaddr(bad_vaddr), .hwi(hwi), .rdata(rdata),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .excp_flush(excp_flush), .ertn_flush(ertn_flush),
        .crmd_plv(crmd_plv), .crmd_ie(crmd_ie)
    );

    csr_checker u_checker (
        .clk(clk), .check_en(check_en), .test_id(test_id), .exp_rdata(exp_rdata),
        .exp_redir(exp_redir), .exp_target(exp_target), .exp_excp(exp_excp),
        .exp_ertn(exp_ertn), .exp_plv(exp_plv), .exp_ie(exp_ie), .rdata(rdata),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .excp_flush(excp_flush), .ertn_flush(ertn_flush),
        .crmd_plv(crmd_plv), .crmd_ie(crmd_ie), .errors(errors)
    );

    task automatic push(input csr_op_e op, input logic [13:0] num, input logic [31:0] wd,
                        input logic [31:0] wm, input logic [31:0] p, input ecode_e ec,
                        input logic [31:0] bv, input logic sc, input logic [31:0] rd,
                        input logic [31:0] alt, input logic redir, input logic [31:0] tgt,
                        input logic ex, input logic er, input logic [1:0] plv,
                        input logic ie);
        row_t r;
        r = '{op, num, wd, wm, p, ec, bv, sc, rd, alt, redir, tgt, ex, er, plv, ie};
        rows.push_back(r);
    endtask

    task automatic read_row(input logic [13:0] num, input logic [31:0] p,
                            input logic [31:0] rd, input logic [31:0] alt,
                            input logic [1:0] plv, input logic ie);
        push(OP_READ, num, 0, 0, p, ECODE_INT, 0, 0, rd, alt, 0, 0, 0, 0, plv, ie);
    endtask

    // write and exchange refetch at pc plus 4
    task automatic write_row(input csr_op_e op, input logic [13:0] num,
                             input logic [31:0] wd, input logic [31:0] wm,
                             input logic [31:0] p, input logic [31:0] old, input logic sc,
                             input logic [1:0] plv, input logic ie);
        push(op, num, wd, wm, p, ECODE_INT, 0, sc, old, old, 1, p + 32'd4, 0, 0, plv, ie);
    endtask

    task automatic excp_row(input ecode_e ec, input logic [13:0] num, input logic [31:0] p,
                            input logic [31:0] bv, input logic [31:0] old);
        push(OP_EXCP, num, 0, 0, p, ec, bv, 0, old, old, 1, EENTRY_VAL, 1, 0, 2'd0, 0);
    endtask

    task automatic apply_row(input row_t r, input int id, input logic only_if_excp,
                             output logic got_excp);
        logic [31:0] draw;
        logic stl;
        @(posedge clk);
        #2;
        draw = $random(seed);
        stl = r.stall_col & draw[0];
        req_valid = 1'b1;
        stall = stl;
        req_op = r.op;
        csr_num = r.num;
        wdata = r.wdata;
        wmask = r.wmask;
        pc = r.pc;
        ecode = r.ecode;
        bad_vaddr = r.badv;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        stall = 1'b0;
        got_excp = redirect_valid & excp_flush;
        // a stalled request leaves no trace
        exp_rdata = prev_stalled ? r.exp_alt : r.exp_rdata;
        exp_redir = r.exp_redir & ~stl;
        exp_target = r.exp_target;
        exp_excp = r.exp_excp & ~stl;
        exp_ertn = r.exp_ertn & ~stl;
        exp_plv = r.exp_plv;
        exp_ie = r.exp_ie;
        test_id = id;
        prev_stalled = stl;
        if (!only_if_excp || got_excp)
        begin
            check_en = 1'b1;
            @(negedge clk);
            #1 check_en = 1'b0;
        end
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("run exceeded its limit of %0d cycles", LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    initial
    begin
        logic seen;
        logic [31:0] int_pc;
        row_t pr;
        int k;
        seed = 29115;
        cycles = 0;
        prev_stalled = 1'b0;
        poll_failed = 1'b0;
        check_en = 1'b0;
        test_id = 0;
        {exp_rdata, exp_redir, exp_target, exp_excp, exp_ertn, exp_plv, exp_ie} = '0;
        req_valid = 1'b0;
        stall = 1'b0;
        req_op = OP_READ;
        csr_num = '0;
        wdata = '0;
        wmask = '0;
        pc = '0;
        ecode = ECODE_INT;
        esubcode = 9'd0;
        bad_vaddr = '0;
        hwi = '0;
        int_pc = '0;

        read_row(CSR_CRMD, 32'h0, 32'h0, 32'h0, 2'd0, 0);
        read_row(CSR_ERA, 32'h0, 32'h0, 32'h0, 2'd0, 0);
        read_row(CSR_ESTAT, 32'h0, 32'h0, 32'h0, 2'd0, 0);
        write_row(OP_WRITE, CSR_SAVE0, 32'h12345678, 32'h0, 32'h100, 32'h0, 0, 2'd0, 0);
        read_row(CSR_SAVE0, 32'h0, 32'h12345678, 32'h12345678, 2'd0, 0);
        write_row(OP_WRITE, CSR_SAVE1, 32'haaaa5555, 32'h0, 32'h108, 32'h0, 0, 2'd0, 0);
        write_row(OP_XCHG, CSR_SAVE1, 32'h0f0f0f0f, 32'h00ff00ff, 32'h110, 32'haaaa5555,
                  0, 2'd0, 0);
        read_row(CSR_SAVE1, 32'h0, 32'haa0f550f, 32'haa0f550f, 2'd0, 0);
        write_row(OP_WRITE, CSR_EENTRY, EENTRY_VAL, 32'h0, 32'h118, 32'h0, 0, 2'd0, 0);
        // plv 3 with interrupts on, no source enabled yet
        write_row(OP_WRITE, CSR_CRMD, 32'h7, 32'h0, 32'h120, 32'h0, 0, 2'd3, 1);
        excp_row(ECODE_ADE, CSR_CRMD, 32'h200, 32'hdeadbeef, 32'h7);
        read_row(CSR_PRMD, 32'h0, 32'h7, 32'h7, 2'd0, 0);
        read_row(CSR_ERA, 32'h0, 32'h200, 32'h200, 2'd0, 0);
        read_row(CSR_BADV, 32'h0, 32'hdeadbeef, 32'hdeadbeef, 2'd0, 0);
        read_row(CSR_ESTAT, 32'h0, 32'h00080000, 32'h00080000, 2'd0, 0);
        push(OP_ERTN, CSR_ERA, 0, 0, 32'h204, ECODE_INT, 0, 0, 32'h200, 32'h200, 1, 32'h200,
             0, 1, 2'd3, 1);
        excp_row(ECODE_SYS, CSR_BADV, 32'h300, 32'h11111111, 32'hdeadbeef);
        read_row(CSR_BADV, 32'h0, 32'hdeadbeef, 32'hdeadbeef, 2'd0, 0);
        read_row(CSR_ESTAT, 32'h0, 32'h000b0000, 32'h000b0000, 2'd0, 0);
        write_row(OP_WRITE, CSR_SAVE2, 32'h5a5a5a5a, 32'h0, 32'h400, 32'h0, 1, 2'd0, 0);
        read_row(CSR_SAVE2, 32'h0, 32'h5a5a5a5a, 32'h0, 2'd0, 0);
        write_row(OP_WRITE, CSR_SAVE3, 32'hc3c3c3c3, 32'h0, 32'h408, 32'h0, 1, 2'd0, 0);
        read_row(CSR_SAVE3, 32'h0, 32'hc3c3c3c3, 32'h0, 2'd0, 0);
        write_row(OP_WRITE, CSR_ECFG, 32'h800, 32'h0, 32'h500, 32'h0, 0, 2'd0, 0);
        write_row(OP_WRITE, CSR_CRMD, 32'h4, 32'h0, 32'h508, 32'h0, 0, 2'd0, 1);
        write_row(OP_WRITE, CSR_TCFG, 32'((INIT_VAL << 2) | 1), 32'h0, 32'h510, 32'h0, 0,
                  2'd0, 1);

        while (!rstn)
        begin
            @(posedge clk);
        end
        for (int i = 0; i < rows.size(); i++)
        begin
            apply_row(rows[i], i, 1'b0, seen);
        end

        // poll ESTAT until the timer interrupt replaces a read
        seen = 1'b0;
        k = 0;
        while (!seen && k < POLL_BOUND)
        begin
            pr = '{OP_READ, CSR_ESTAT, 0, 0, 32'h600 + 32'(k * 4), ECODE_INT, 0, 0,
                   32'h000b0800, 32'h000b0800, 1, EENTRY_VAL, 1, 0, 2'd0, 0};
            apply_row(pr, rows.size(), 1'b1, seen);
            int_pc = pr.pc;
            k++;
        end
        if (!seen)
        begin
            $display("timer interrupt did not arrive within %0d polls", POLL_BOUND);
            poll_failed = 1'b1;
        end

        rows.delete();
        read_row(CSR_ERA, 32'h0, int_pc, int_pc, 2'd0, 0);
        read_row(CSR_ESTAT, 32'h0, 32'h00000800, 32'h00000800, 2'd0, 0);
        write_row(OP_WRITE, CSR_TICLR, 32'h1, 32'h0, 32'h700, 32'h0, 0, 2'd0, 0);
        read_row(CSR_ESTAT, 32'h0, 32'h0, 32'h0, 2'd0, 0);
        for (int i = 0; i < rows.size(); i++)
        begin
            apply_row(rows[i], 100 + i, 1'b0, seen);
        end

        @(posedge clk);
        u_checker.print_counts();
        if (errors == 0 && !poll_failed)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
verilog/csr_pkg.sv
verilog/csr_issue_ctrl.sv
verilog/csr_regfile.sv
verilog/csr_timer.sv
verilog/csr_unit.sv
bench/tb_clock_gen.sv
bench/csr_checker.sv
bench/csr_unit_assertions.sv
bench/tb_csr_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_csr_unit
FILELIST  := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard verilog/*.sv bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
